// File: filelist.f
+incdir+rtl
rtl/piano_pkg.sv
rtl/ps2_key_decoder.sv
rtl/note_selector.sv
rtl/note_gen.sv
rtl/speaker_serializer.sv
rtl/keyboard_piano.sv
bench/tb_keyboard_piano.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_keyboard_piano
FILELIST := filelist.f
OBJ_DIR  := obj_dir
PASS_MSG := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_keyboard_piano.sv
`timescale 1ns/1ps
`default_nettype none

`include "piano_defs.svh"

module tb_keyboard_piano;

    localparam int BIT_CYCLES    = 20;                  // PS/2 clock period in clk cycles
    localparam int FRAME_CYCLES  = 11 * BIT_CYCLES + 21;
    localparam int N_FRAMES      = 40;
    localparam int N_AUDIO_WAITS = 20;                  // each waits for two left/right pairs
    localparam int TIMEOUT_CYCLES = (N_FRAMES * FRAME_CYCLES + N_AUDIO_WAITS * 2 * 512
                                     + `PS2_IDLE_CYCLES + 200) * 3 / 2;
    localparam bit [6:0] OCT_STEPS_UP = 7'b1000111;     // bit 0 first and a 1 is an up pulse
    localparam bit [9:0] VOL_STEPS_UP = 10'b1100000111;

    logic             clk;
    logic             out_rst;
    logic             ps2_clk;
    logic             ps2_data;
    logic             vol_up;
    logic             vol_down;
    logic             oct_up;
    logic             oct_down;
    piano_pkg::note_t note;
    logic [2:0]       octave;
    logic [4:0]       vol_led;
    logic             audio_mclk;
    logic             audio_lrck;
    logic             audio_sck;
    logic             audio_sdin;

    logic               sck_q;
    logic               lrck_q;
    logic               mclk_q;
    int                 mclk_run;      // samples since the last mclk change
    int                 rise_cnt;      // sck rises since the last lrck edge
    logic [15:0]        shift_word;
    logic signed [15:0] left_word;
    logic signed [15:0] right_word;
    int                 pairs_seen;
    int                 cycles;
    int                 errors;
    int                 errors_at_start;
    int                 tests_run;
    int                 tests_failed;
    string              cur_test;
    logic [31:0]        lfsr_state;

    keyboard_piano i_keyboard_piano (
        .clk        (clk),
        .out_rst    (out_rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .vol_up     (vol_up),
        .vol_down   (vol_down),
        .oct_up     (oct_up),
        .oct_down   (oct_down),
        .note       (note),
        .octave     (octave),
        .vol_led    (vol_led),
        .audio_mclk (audio_mclk),
        .audio_lrck (audio_lrck),
        .audio_sck  (audio_sck),
        .audio_sdin (audio_sdin)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // rebuild each channel word after its one padding sck period
    always @(posedge clk) begin
        if (out_rst) begin
            sck_q    <= 1'b0;
            lrck_q   <= 1'b0;
            mclk_q   <= 1'b0;
            mclk_run <= 0;
            rise_cnt <= 0;
        end else begin
            sck_q  <= audio_sck;
            lrck_q <= audio_lrck;
            mclk_q <= audio_mclk;
            if (audio_mclk != mclk_q) begin
                mclk_run <= 1;
                assert (mclk_run == 2) else begin
                    $display("audio_mclk held a level for %0d cycles instead of 2", mclk_run);
                    errors++;
                end
            end else begin
                mclk_run <= mclk_run + 1;
            end
            if (audio_lrck != lrck_q) begin
                rise_cnt <= 0;
            end else if (audio_sck && !sck_q) begin
                rise_cnt <= rise_cnt + 1;
                if (rise_cnt >= 1 && rise_cnt <= 16)
                    shift_word <= {shift_word[14:0], audio_sdin};
                if (rise_cnt == 16 && !audio_lrck)
                    left_word <= {shift_word[14:0], audio_sdin};
                if (rise_cnt == 16 && audio_lrck) begin
                    right_word <= {shift_word[14:0], audio_sdin};
                    pairs_seen <= pairs_seen + 1;
                    assert ({shift_word[14:0], audio_sdin} == left_word) else begin
                        $display("Mismatch in %s (right word): expected %h, actual %h",
                                 cur_test, left_word, {shift_word[14:0], audio_sdin});
                        errors++;
                    end
                end
            end
        end
    end

    a_led_thermometer: assert property (@(posedge clk) disable iff (out_rst)
        vol_led inside {5'b00001, 5'b00011, 5'b00111, 5'b01111, 5'b11111})
        else begin
            $display("vol_led %b is not a thermometer code", vol_led);
            errors++;
        end

    a_octave_limits: assert property (@(posedge clk) disable iff (out_rst)
        octave >= 3'(`OCT_MIN) && octave <= 3'(`OCT_MAX))
        else begin
            $display("octave %0d left the allowed range", octave);
            errors++;
        end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            lfsr_next = (s >> 1) ^ 32'h8020_0003;
        else
            lfsr_next = s >> 1;
    endfunction

    function automatic logic [7:0] scan_code_of(input int idx);
        case (idx)
            0:       scan_code_of = 8'h1C;   // A
            1:       scan_code_of = 8'h1B;   // S
            2:       scan_code_of = 8'h23;
            3:       scan_code_of = 8'h2B;
            4:       scan_code_of = 8'h34;
            5:       scan_code_of = 8'h33;
            6:       scan_code_of = 8'h3B;
            default: scan_code_of = 8'h42;   // K
        endcase
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // start, 8 data bits lsb first, odd parity and stop bit
    // fewer than 11 bits leaves a cut frame
    task automatic send_frame(input logic [7:0] data, input bit bad_parity, input int nbits);
        logic [10:0] frame;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        @(posedge clk);
        for (int i = 0; i < nbits; i++) begin
            ps2_data <= frame[i];
            repeat (BIT_CYCLES / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (BIT_CYCLES / 2) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
        repeat (BIT_CYCLES) @(posedge clk);
    endtask

    task automatic press_key(input logic [7:0] code);
        send_frame(code, 1'b0, 11);
    endtask

    task automatic release_key(input logic [7:0] code);
        send_frame(`PS2_BREAK, 1'b0, 11);
        send_frame(code, 1'b0, 11);
    endtask

    task automatic pulse_button(input bit is_volume, input bit up);
        @(posedge clk);
        if (is_volume && up)
            vol_up <= 1'b1;
        else if (is_volume)
            vol_down <= 1'b1;
        else if (up)
            oct_up <= 1'b1;
        else
            oct_down <= 1'b1;
        @(posedge clk);
        vol_up   <= 1'b0;
        vol_down <= 1'b0;
        oct_up   <= 1'b0;
        oct_down <= 1'b0;
        repeat (2) @(posedge clk);   // vol_led trails volume by a cycle
    endtask

    task automatic wait_pairs(input int n);
        int target;
        target = pairs_seen + n;
        while (pairs_seen < target)
            @(posedge clk);
    endtask

    // newest left word against volume * 4096
    task automatic check_audio(input int vol);
        int mag;
        wait_pairs(2);
        mag = (left_word < 0) ? -int'(left_word) : int'(left_word);
        check_value("audio magnitude", vol * 4096, mag);
        check_value("right word", int'(left_word), int'(right_word));
    endtask

    initial begin
        int idx;
        int exp_oct;
        int exp_vol;
        int held;
        out_rst    = 1'b1;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        vol_up     = 1'b0;
        vol_down   = 1'b0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        shift_word = 16'd0;
        left_word  = 16'sd0;
        right_word = 16'sd0;
        pairs_seen = 0;
        cycles     = 0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        cur_test   = "reset_state";
        lfsr_state = 32'h248e;
        repeat (5) @(posedge clk);
        out_rst <= 1'b0;
        @(posedge clk);

        start_test("reset_state");
        check_value("note", 0, int'(note));
        check_value("octave", `OCT_RESET, int'(octave));
        check_value("vol_led", 7, int'(vol_led));
        check_value("audio_mclk", 0, int'(audio_mclk));
        check_value("audio_sck", 0, int'(audio_sck));
        check_value("audio_lrck", 0, int'(audio_lrck));
        check_value("audio_sdin", 0, int'(audio_sdin));
        wait_pairs(2);
        check_value("left word", 0, int'(left_word));
        check_value("right word", 0, int'(right_word));
        finish_test();

        start_test("key_press_release");
        for (int k = 0; k < 8; k++) begin
            take_bits(3, idx);
            press_key(scan_code_of(idx));
            check_value("note after make", idx + 1, int'(note));
            check_audio(`VOL_RESET);
            if (k == 0) begin
                release_key(scan_code_of((idx + 1) % 8));      // another key's break
                check_value("note after other break", idx + 1, int'(note));
                press_key(8'h15);                              // unmapped code
                check_value("note after unmapped make", idx + 1, int'(note));
                send_frame(`PS2_EXTEND, 1'b0, 11);
                press_key(8'h1C);
                check_value("note after extended make", idx + 1, int'(note));
            end
            release_key(scan_code_of(idx));
            check_value("note after break", 0, int'(note));
        end
        finish_test();

        start_test("bad_frame");
        send_frame(scan_code_of(3), 1'b1, 11);
        check_value("note after bad parity", 0, int'(note));
        send_frame(scan_code_of(2), 1'b0, 5);                  // start and four data bits
        repeat (`PS2_IDLE_CYCLES + 20) @(posedge clk);
        press_key(scan_code_of(1));
        check_value("note after cut frame", 2, int'(note));
        release_key(scan_code_of(1));
        check_value("note after break", 0, int'(note));
        finish_test();

        start_test("octave");
        take_bits(3, held);
        press_key(scan_code_of(held));
        exp_oct = `OCT_RESET;
        for (int i = 0; i < 7; i++) begin
            pulse_button(1'b0, OCT_STEPS_UP[i]);
            if (OCT_STEPS_UP[i] && exp_oct < `OCT_MAX)
                exp_oct++;
            else if (!OCT_STEPS_UP[i] && exp_oct > `OCT_MIN)
                exp_oct--;
            check_value("octave", exp_oct, int'(octave));
            check_value("held note", held + 1, int'(note));
        end
        release_key(scan_code_of(held));
        finish_test();

        start_test("volume");
        take_bits(3, held);
        press_key(scan_code_of(held));
        exp_vol = `VOL_RESET;
        check_audio(exp_vol);
        for (int i = 0; i < 10; i++) begin
            pulse_button(1'b1, VOL_STEPS_UP[i]);
            if (VOL_STEPS_UP[i] && exp_vol < `VOL_MAX)
                exp_vol++;
            else if (!VOL_STEPS_UP[i] && exp_vol > `VOL_MIN)
                exp_vol--;
            check_value("vol_led", (1 << exp_vol) - 1, int'(vol_led));
            check_audio(exp_vol);
        end
        release_key(scan_code_of(held));
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/keyboard_piano.sv
`timescale 1ns/1ps
`default_nettype none

module keyboard_piano (
    input  wire              clk,
    input  wire              out_rst,
    input  wire              ps2_clk,
    input  wire              ps2_data,
    input  wire              vol_up,      // one-cycle pulses from board logic
    input  wire              vol_down,
    input  wire              oct_up,
    input  wire              oct_down,
    output piano_pkg::note_t note,        // to the external display
    output logic [2:0]       octave,
    output logic [4:0]       vol_led,
    output logic             audio_mclk,
    output logic             audio_lrck,
    output logic             audio_sck,
    output logic             audio_sdin
);

    logic [8:0]         key_code;
    logic               key_make;
    logic               key_break;
    logic [2:0]         volume;
    logic [21:0]        note_div;
    logic signed [15:0] audio_left;
    logic signed [15:0] audio_right;

    ps2_key_decoder i_ps2_key_decoder (
        .clk       (clk),
        .out_rst   (out_rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .key_code  (key_code),
        .key_make  (key_make),
        .key_break (key_break)
    );

    note_selector i_note_selector (
        .clk       (clk),
        .out_rst   (out_rst),
        .key_code  (key_code),
        .key_make  (key_make),
        .key_break (key_break),
        .vol_up    (vol_up),
        .vol_down  (vol_down),
        .oct_up    (oct_up),
        .oct_down  (oct_down),
        .note      (note),
        .octave    (octave),
        .volume    (volume),
        .vol_led   (vol_led),
        .note_div  (note_div)
    );

    note_gen i_note_gen (
        .clk         (clk),
        .out_rst     (out_rst),
        .note_div    (note_div),
        .volume      (volume),
        .audio_left  (audio_left),
        .audio_right (audio_right)
    );

    speaker_serializer i_speaker_serializer (
        .clk         (clk),
        .out_rst     (out_rst),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .audio_mclk  (audio_mclk),
        .audio_lrck  (audio_lrck),
        .audio_sck   (audio_sck),
        .audio_sdin  (audio_sdin)
    );

endmodule

`default_nettype wire

// File: rtl/speaker_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module speaker_serializer (
    input  wire        clk,
    input  wire        out_rst,
    input  wire [15:0] audio_left,
    input  wire [15:0] audio_right,
    output logic       audio_mclk,
    output logic       audio_lrck,
    output logic       audio_sck,
    output logic       audio_sdin
);

    logic [8:0]  div_cnt;       // one channel is 256 clk, 32 sck periods
    logic [15:0] right_q;       // right word held until the lrck rise
    logic [15:0] shift;
    logic [4:0]  slot;          // sck period within the channel

    assign audio_mclk = div_cnt[1];
    assign audio_sck  = div_cnt[2];
    assign audio_lrck = div_cnt[8];
    assign slot       = div_cnt[7:3];

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            div_cnt    <= 9'd0;
            right_q    <= 16'd0;
            shift      <= 16'd0;
            audio_sdin <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 9'd1;
            if (div_cnt == 9'd511) begin
                // lrck falls, take both samples
                shift      <= audio_left;
                right_q    <= audio_right;
                audio_sdin <= 1'b0;
            end else if (div_cnt == 9'd255) begin
                shift      <= right_q;       // lrck rises
                audio_sdin <= 1'b0;
            end else if (div_cnt[2:0] == 3'd7) begin
                // next edge is an sck fall
                if (slot < 5'd16) begin
                    audio_sdin <= shift[15];
                    shift      <= {shift[14:0], 1'b0};
                end else begin
                    audio_sdin <= 1'b0;      // pad to the end of the channel
                end
            end
        end
    end

    a_sdin_on_sck_fall: assert property (@(posedge clk) disable iff (out_rst)
        $changed(audio_sdin) |-> $fell(audio_sck));

endmodule

`default_nettype wire

// File: rtl/note_gen.sv
`timescale 1ns/1ps
`default_nettype none

module note_gen (
    input  wire                clk,
    input  wire                out_rst,
    input  wire         [21:0] note_div,
    input  wire         [2:0]  volume,
    output logic signed [15:0] audio_left,
    output logic signed [15:0] audio_right
);

    logic [21:0]        half_cnt;
    logic [21:0]        div_q;         // last divisor, to catch a change
    logic               polarity;
    logic signed [15:0] amplitude;
    logic signed [15:0] sample;

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            half_cnt <= 22'd0;
            div_q    <= 22'd0;
            polarity <= 1'b0;
        end else begin
            div_q <= note_div;
            if (note_div != div_q || note_div == 22'd0) begin
                half_cnt <= 22'd0;            // new note restarts the half period
            end else if (half_cnt == note_div - 22'd1) begin
                half_cnt <= 22'd0;
                polarity <= ~polarity;
            end else begin
                half_cnt <= half_cnt + 22'd1;
            end
        end
    end

    // volume * 4096
    assign amplitude = {1'b0, volume, 12'd0};

    always_comb begin
        if (note_div == 22'd0)
            sample = 16'sd0;
        else if (polarity)
            sample = amplitude;
        else
            sample = -amplitude;
    end

    // same note on both channels
    assign audio_left  = sample;
    assign audio_right = sample;

endmodule

`default_nettype wire

// File: rtl/note_selector.sv
`timescale 1ns/1ps
`default_nettype none

`include "piano_defs.svh"

module note_selector (
    input  wire               clk,
    input  wire               out_rst,
    input  wire  [8:0]        key_code,
    input  wire               key_make,
    input  wire               key_break,
    input  wire               vol_up,
    input  wire               vol_down,
    input  wire               oct_up,
    input  wire               oct_down,
    output piano_pkg::note_t  note,
    output logic [2:0]        octave,
    output logic [2:0]        volume,
    output logic [4:0]        vol_led,
    output logic [21:0]       note_div
);

    piano_pkg::note_t mapped;
    piano_pkg::note_t note_next;
    logic [2:0]       octave_next;
    logic [8:0]       held_code;       // code of the key now sounding

    function automatic piano_pkg::note_t key_to_note(input logic [7:0] code);
        case (code)
            8'h1C:   key_to_note = piano_pkg::NOTE_C;
            8'h1B:   key_to_note = piano_pkg::NOTE_D;
            8'h23:   key_to_note = piano_pkg::NOTE_E;
            8'h2B:   key_to_note = piano_pkg::NOTE_F;
            8'h34:   key_to_note = piano_pkg::NOTE_G;
            8'h33:   key_to_note = piano_pkg::NOTE_A;
            8'h3B:   key_to_note = piano_pkg::NOTE_B;
            8'h42:   key_to_note = piano_pkg::NOTE_C_HI;
            default: key_to_note = piano_pkg::NOTE_SILENCE;
        endcase
    endfunction

    // half period for a note at a given octave, zero while silent
    function automatic logic [21:0] half_period(input piano_pkg::note_t n,
                                                input logic [2:0] oct);
        logic [21:0] base;
        case (n)
            piano_pkg::NOTE_C:    base = 22'(`DIV_C4);
            piano_pkg::NOTE_D:    base = 22'(`DIV_D4);
            piano_pkg::NOTE_E:    base = 22'(`DIV_E4);
            piano_pkg::NOTE_F:    base = 22'(`DIV_F4);
            piano_pkg::NOTE_G:    base = 22'(`DIV_G4);
            piano_pkg::NOTE_A:    base = 22'(`DIV_A4);
            piano_pkg::NOTE_B:    base = 22'(`DIV_B4);
            piano_pkg::NOTE_C_HI: base = 22'(`DIV_C5);
            default:              base = 22'd0;
        endcase
        if (oct == 3'(`OCT_MAX))
            half_period = base >> 1;   // octave up, half the period
        else if (oct == 3'(`OCT_MIN))
            half_period = base << 1;
        else
            half_period = base;
    endfunction

    always_comb begin
        mapped    = key_to_note(key_code[7:0]);
        note_next = note;
        if (key_make && !key_code[8] && mapped != piano_pkg::NOTE_SILENCE)
            note_next = mapped;
        else if (key_break && key_code == held_code && note != piano_pkg::NOTE_SILENCE)
            note_next = piano_pkg::NOTE_SILENCE;

        octave_next = octave;
        if (oct_up) begin
            if (octave < 3'(`OCT_MAX))
                octave_next = octave + 3'd1;
        end else if (oct_down) begin
            if (octave > 3'(`OCT_MIN))
                octave_next = octave - 3'd1;
        end
    end

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            note      <= piano_pkg::NOTE_SILENCE;
            held_code <= 9'd0;
            octave    <= 3'(`OCT_RESET);
            volume    <= 3'(`VOL_RESET);
            vol_led   <= 5'b00111;
            note_div  <= 22'd0;
        end else begin
            note     <= note_next;
            octave   <= octave_next;
            note_div <= half_period(note_next, octave_next);
            if (key_make && !key_code[8] && mapped != piano_pkg::NOTE_SILENCE)
                held_code <= key_code;

            if (vol_up) begin
                if (volume < 3'(`VOL_MAX))
                    volume <= volume + 3'd1;
            end else if (vol_down) begin
                if (volume > 3'(`VOL_MIN))
                    volume <= volume - 3'd1;
            end

            vol_led <= 5'((6'd1 << volume) - 6'd1);  // thermometer, one step behind
        end
    end

    a_octave_range: assert property (@(posedge clk) disable iff (out_rst)
        octave >= 3'(`OCT_MIN) && octave <= 3'(`OCT_MAX));

    a_volume_range: assert property (@(posedge clk) disable iff (out_rst)
        volume >= 3'(`VOL_MIN) && volume <= 3'(`VOL_MAX));

endmodule

`default_nettype wire

// File: rtl/ps2_key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "piano_defs.svh"

module ps2_key_decoder (
    input  wire        clk,
    input  wire        out_rst,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    output logic [8:0] key_code,
    output logic       key_make,
    output logic       key_break
);

    logic [1:0]            clk_sync;       // two-flop synchronizers
    logic [1:0]            data_sync;
    logic                  clk_last;       // delayed synced clock for edge detect
    logic                  ps2_fall;
    logic                  bit_in;
    logic                  frame_ok;
    piano_pkg::ps2_state_t state;
    logic [2:0]            bit_cnt;
    logic [7:0]            shift;
    logic                  parity_ok;
    logic [11:0]           idle_cnt;
    logic                  ext_seen;       // E0 seen, waiting for the code byte
    logic                  brk_seen;       // F0 seen, waiting for the code byte

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            clk_sync  <= 2'b11;    // lines idle high
            data_sync <= 2'b11;
            clk_last  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_last  <= clk_sync[1];
        end
    end

    assign ps2_fall = clk_last & ~clk_sync[1];
    assign bit_in   = data_sync[1];
    assign frame_ok = parity_ok & bit_in;  // valid in RX_STOP only

    always_ff @(posedge clk or posedge out_rst) begin
        if (out_rst) begin
            state     <= piano_pkg::RX_IDLE;
            bit_cnt   <= 3'd0;
            parity_ok <= 1'b0;
            idle_cnt  <= 12'd0;
            ext_seen  <= 1'b0;
            brk_seen  <= 1'b0;
            key_make  <= 1'b0;
            key_break <= 1'b0;
        end else begin
            key_make  <= 1'b0;
            key_break <= 1'b0;
            if (state == piano_pkg::RX_IDLE || ps2_fall)
                idle_cnt <= 12'd0;
            else
                idle_cnt <= idle_cnt + 12'd1;

            case (state)
                piano_pkg::RX_IDLE: begin
                    if (ps2_fall && !bit_in) begin     // start bit
                        state   <= piano_pkg::RX_DATA;
                        bit_cnt <= 3'd0;
                    end
                end
                piano_pkg::RX_DATA: begin
                    if (ps2_fall) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= piano_pkg::RX_PARITY;
                    end
                end
                piano_pkg::RX_PARITY: begin
                    if (ps2_fall) begin
                        parity_ok <= ^{shift, bit_in};  // odd count of ones
                        state     <= piano_pkg::RX_STOP;
                    end
                end
                piano_pkg::RX_STOP: begin
                    if (ps2_fall) begin
                        state <= piano_pkg::RX_IDLE;
                        if (frame_ok) begin
                            if (shift == `PS2_EXTEND) begin
                                ext_seen <= 1'b1;
                            end else if (shift == `PS2_BREAK) begin
                                brk_seen <= 1'b1;
                            end else begin
                                key_make  <= ~brk_seen;
                                key_break <= brk_seen;
                                ext_seen  <= 1'b0;
                                brk_seen  <= 1'b0;
                            end
                        end
                    end
                end
                default: state <= piano_pkg::RX_IDLE;
            endcase

            // stalled frame, drop it
            if (state != piano_pkg::RX_IDLE && !ps2_fall &&
                idle_cnt == 12'(`PS2_IDLE_CYCLES - 1))
                state <= piano_pkg::RX_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == piano_pkg::RX_DATA && ps2_fall)
            shift <= {bit_in, shift[7:1]};
        if (state == piano_pkg::RX_STOP && ps2_fall && frame_ok)
            key_code <= {ext_seen, shift};
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (out_rst)
        !(key_make && key_break));

endmodule

`default_nettype wire

// File: rtl/piano_pkg.sv
`default_nettype none

package piano_pkg;

    // notes of the eight piano keys, silence first
    typedef enum logic [3:0] {
        NOTE_SILENCE = 4'd0,
        NOTE_C       = 4'd1,    // key A
        NOTE_D       = 4'd2,    // key S
        NOTE_E       = 4'd3,    // key D
        NOTE_F       = 4'd4,    // key F
        NOTE_G       = 4'd5,    // key G
        NOTE_A       = 4'd6,    // key H
        NOTE_B       = 4'd7,    // key J
        NOTE_C_HI    = 4'd8     // key K, one octave up
    } note_t;

    // PS/2 frame receiver states
    // the start bit is taken in RX_IDLE
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,       // waiting for a start bit
        RX_DATA   = 2'd1,       // eight data bits, lsb first
        RX_PARITY = 2'd2,       // odd parity bit
        RX_STOP   = 2'd3        // stop bit, must be high
    } ps2_state_t;

endpackage

`default_nettype wire

// File: rtl/piano_defs.svh
`ifndef PIANO_DEFS_SVH
`define PIANO_DEFS_SVH

// system clock
`define CLK_HZ          100000000

// PS/2 receiver
`define PS2_IDLE_CYCLES 4000        // clk cycles without a ps2_clk fall before a frame is dropped
`define PS2_BREAK       8'hF0       // break prefix
`define PS2_EXTEND      8'hE0       // extended-code prefix

// octave-4 half periods in clk cycles, clock / 2 / note frequency
`define DIV_C4          (`CLK_HZ / 2 / 262)
`define DIV_D4          (`CLK_HZ / 2 / 294)
`define DIV_E4          (`CLK_HZ / 2 / 330)
`define DIV_F4          (`CLK_HZ / 2 / 349)
`define DIV_G4          (`CLK_HZ / 2 / 392)
`define DIV_A4          (`CLK_HZ / 2 / 440)
`define DIV_B4          (`CLK_HZ / 2 / 494)
`define DIV_C5          (`CLK_HZ / 2 / 523)

// octave and volume ranges
`define OCT_MIN         3
`define OCT_MAX         5
`define OCT_RESET       4
`define VOL_MIN         1
`define VOL_MAX         5
`define VOL_RESET       3

`endif
